/* logic/cdc_dst_drain.sv */
// Read half of the Gray-pointer async FIFO, clocked by the reference clock
// Presents one registered beat per pulse of out_valid_o unless held

`timescale 1ns/10ps

`include "secure_out_defs.svh"

module cdc_dst_drain (
   input  logic                        clk_ref_i,
   input  logic                        reset_i,
   input  secure_out_pkg::beat_store_t store_i,
   input  secure_out_pkg::gray_ptr_t   wptr_gray_i,
   output secure_out_pkg::gray_ptr_t   rptr_gray_o,
   input  logic                        out_hold_i,
   output logic                        out_valid_o,
   output secure_out_pkg::wide_beat_t  out_beat_o
);

   import secure_out_pkg::*;

   // Write pointer synchronizer
   gray_ptr_t                      wptr_meta_q;
   gray_ptr_t                      wptr_sync_q;

   logic [`SECURE_OUT_LOG_DEPTH:0] rbin_q;
   logic [`SECURE_OUT_LOG_DEPTH:0] rbin_next;
   gray_ptr_t                      rgray_q;
   gray_ptr_t                      rgray_next;

   logic                           fifo_empty;
   logic                           rd_en;

   logic                           out_valid_q;
   wide_beat_t                     out_beat_q;

   assign fifo_empty = (rgray_q == wptr_sync_q);
   assign rd_en      = ~fifo_empty & ~out_hold_i;

   assign rbin_next  = rbin_q + 1'b1;
   assign rgray_next = rbin_next ^ (rbin_next >> 1);

   always_ff @(posedge clk_ref_i) begin
      if (reset_i) begin
         wptr_meta_q <= '0;
         wptr_sync_q <= '0;
         rbin_q      <= '0;
         rgray_q     <= '0;
         out_valid_q <= 1'b0;
      end else begin
         wptr_meta_q <= wptr_gray_i;
         wptr_sync_q <= wptr_meta_q;
         out_valid_q <= rd_en;
         if (rd_en) begin
            rbin_q  <= rbin_next;
            rgray_q <= rgray_next;
         end
      end
   end

   // Slot stays stable until the read pointer has moved past it
   always_ff @(posedge clk_ref_i) begin
      if (rd_en) begin
         out_beat_q <= store_i[rbin_q[`SECURE_OUT_LOG_DEPTH-1:0]];
      end
   end

   assign rptr_gray_o = rgray_q;
   assign out_valid_o = out_valid_q;
   assign out_beat_o  = out_beat_q;

endmodule

/* logic/cdc_src_fifo.sv */
// Write half of the Gray-pointer async FIFO, clocked by the core clock
// Exports the slot storage and the Gray write pointer to the drain side
// and brings the drain's read pointer back through two flops

`timescale 1ns/10ps

`include "secure_out_defs.svh"

module cdc_src_fifo (
   input  logic                        clk_i,
   input  logic                        reset_i,
   input  logic                        beat_valid_i,
   input  secure_out_pkg::wide_beat_t  beat_i,
   output logic                        fifo_full_o,
   output secure_out_pkg::beat_store_t store_o,
   output secure_out_pkg::gray_ptr_t   wptr_gray_o,
   input  secure_out_pkg::gray_ptr_t   rptr_gray_i
);

   import secure_out_pkg::*;

   beat_store_t                    store_q;

   logic [`SECURE_OUT_LOG_DEPTH:0] wbin_q;
   logic [`SECURE_OUT_LOG_DEPTH:0] wbin_next;
   gray_ptr_t                      wgray_q;
   gray_ptr_t                      wgray_next;

   // Read pointer synchronizer
   gray_ptr_t                      rptr_meta_q;
   gray_ptr_t                      rptr_sync_q;

   gray_ptr_t                      full_gray;
   logic                           wr_en;

   // Full when write leads read by the depth with the top two Gray bits flipped
   assign full_gray = rptr_sync_q ^ {2'b11, {(`SECURE_OUT_LOG_DEPTH - 1){1'b0}}};
   assign fifo_full_o = (wgray_q == full_gray);

   assign wr_en      = beat_valid_i & ~fifo_full_o;
   assign wbin_next  = wbin_q + 1'b1;
   assign wgray_next = wbin_next ^ (wbin_next >> 1);

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         wbin_q      <= '0;
         wgray_q     <= '0;
         rptr_meta_q <= '0;
         rptr_sync_q <= '0;
      end else begin
         rptr_meta_q <= rptr_gray_i;
         rptr_sync_q <= rptr_meta_q;
         if (wr_en) begin
            wbin_q  <= wbin_next;
            wgray_q <= wgray_next;
         end
      end
   end

   // Slot and pointer move on the same edge
   always_ff @(posedge clk_i) begin
      if (wr_en) begin
         store_q[wbin_q[`SECURE_OUT_LOG_DEPTH-1:0]] <= beat_i;
      end
   end

   assign store_o     = store_q;
   assign wptr_gray_o = wgray_q;

endmodule

/* logic/secure_out_defs.svh */
// Width and depth constants for the secure outbound write path
// Included by the package and by every module that sizes logic from them

`ifndef SECURE_OUT_DEFS_SVH
`define SECURE_OUT_DEFS_SVH

// Core side word and bus side beat
`define SECURE_OUT_NARROW_W   32
`define SECURE_OUT_WIDE_W     64
`define SECURE_OUT_ADDR_W     32

// One byte enable per byte of a beat
`define SECURE_OUT_STRB_W     (`SECURE_OUT_WIDE_W / 8)

// Async FIFO holds 2**LOG_DEPTH beats
`define SECURE_OUT_LOG_DEPTH  2
`define SECURE_OUT_DEPTH      (1 << `SECURE_OUT_LOG_DEPTH)

`endif

/* logic/secure_out_path.sv */
// Outbound write path of the secure subsystem wrapper
// Core words are upsized in the clk_i domain, then cross into clk_ref_i
// through the split async FIFO and leave on the wide port

`timescale 1ns/10ps

module secure_out_path (
   input  logic                        clk_i,
   input  logic                        clk_ref_i,
   input  logic                        reset_i,
   // Core side, clk_i
   input  logic                        req_valid_i,
   input  secure_out_pkg::narrow_req_t req_i,
   output logic                        busy_o,
   // Wide side, clk_ref_i
   input  logic                        out_hold_i,
   output logic                        out_valid_o,
   output secure_out_pkg::wide_beat_t  out_beat_o
);

   import secure_out_pkg::*;

   logic        beat_valid;
   wide_beat_t  beat;
   logic        fifo_full;

   // Signals across the clock boundary
   beat_store_t store;
   gray_ptr_t   wptr_gray;
   gray_ptr_t   rptr_gray;

   word_upsizer u_word_upsizer (
      .clk_i        ( clk_i       ),
      .reset_i      ( reset_i     ),
      .req_valid_i  ( req_valid_i ),
      .req_i        ( req_i       ),
      .fifo_full_i  ( fifo_full   ),
      .beat_valid_o ( beat_valid  ),
      .beat_o       ( beat        ),
      .busy_o       ( busy_o      )
   );

   cdc_src_fifo u_cdc_src_fifo (
      .clk_i        ( clk_i      ),
      .reset_i      ( reset_i    ),
      .beat_valid_i ( beat_valid ),
      .beat_i       ( beat       ),
      .fifo_full_o  ( fifo_full  ),
      .store_o      ( store      ),
      .wptr_gray_o  ( wptr_gray  ),
      .rptr_gray_i  ( rptr_gray  )
   );

   cdc_dst_drain u_cdc_dst_drain (
      .clk_ref_i   ( clk_ref_i   ),
      .reset_i     ( reset_i     ),
      .store_i     ( store       ),
      .wptr_gray_i ( wptr_gray   ),
      .rptr_gray_o ( rptr_gray   ),
      .out_hold_i  ( out_hold_i  ),
      .out_valid_o ( out_valid_o ),
      .out_beat_o  ( out_beat_o  )
   );

endmodule

/* logic/secure_out_pkg.sv */
// Types shared by the outbound path blocks and the testbench
// Widths come from the define header

`include "secure_out_defs.svh"

package secure_out_pkg;

   typedef logic [`SECURE_OUT_NARROW_W-1:0]  narrow_word_t;
   typedef logic [`SECURE_OUT_WIDE_W-1:0]    wide_word_t;
   typedef logic [`SECURE_OUT_STRB_W-1:0]    wide_strb_t;
   typedef logic [`SECURE_OUT_ADDR_W-1:0]    bus_addr_t;

   // Extra MSB tells a full FIFO from an empty one
   typedef logic [`SECURE_OUT_LOG_DEPTH:0]   gray_ptr_t;

   // One core write word
   typedef struct packed {
      bus_addr_t    addr;
      narrow_word_t data;
      logic         last;    // final word of a burst
   } narrow_req_t;

   // Upsized beat as it leaves on the wide bus
   typedef struct packed {
      bus_addr_t  addr;
      wide_word_t data;
      wide_strb_t strb;
   } wide_beat_t;

   // All FIFO slots, visible to the reference clock side
   typedef wide_beat_t [`SECURE_OUT_DEPTH-1:0] beat_store_t;

   typedef enum logic {
      UPS_EMPTY,
      UPS_HALF
   } upsizer_state_t;

endpackage

/* logic/word_upsizer.sv */
// Packs pairs of 32-bit core writes into 64-bit beats with byte strobes
// A lone last word is flushed with the upper half disabled
// A finished beat waits in its register until the FIFO has room

`timescale 1ns/10ps

`include "secure_out_defs.svh"

module word_upsizer (
   input  logic                        clk_i,
   input  logic                        reset_i,
   input  logic                        req_valid_i,
   input  secure_out_pkg::narrow_req_t req_i,
   input  logic                        fifo_full_i,
   output logic                        beat_valid_o,
   output secure_out_pkg::wide_beat_t  beat_o,
   output logic                        busy_o
);

   import secure_out_pkg::*;

   upsizer_state_t state_q;
   logic           pend_q;

   bus_addr_t      half_addr_q;
   narrow_word_t   half_data_q;
   wide_beat_t     beat_q;

   logic           beat_done;
   wide_beat_t     beat_next;

   // Beat completes on the second word of a pair or on a lone last word
   always_comb begin
      beat_done = 1'b0;
      beat_next = '0;
      if (req_valid_i) begin
         if (state_q == UPS_HALF) begin
            beat_done      = 1'b1;
            beat_next.addr = half_addr_q;
            beat_next.data = {req_i.data, half_data_q};
            beat_next.strb = '1;
         end else if (req_i.last) begin
            beat_done      = 1'b1;
            beat_next.addr = req_i.addr;
            beat_next.data = {narrow_word_t'(0), req_i.data};
            beat_next.strb = {{(`SECURE_OUT_STRB_W / 2){1'b0}},
                              {(`SECURE_OUT_STRB_W / 2){1'b1}}};
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q <= UPS_EMPTY;
         pend_q  <= 1'b0;
      end else begin
         if (req_valid_i) begin
            if (state_q == UPS_EMPTY && !req_i.last) begin
               state_q <= UPS_HALF;
            end else begin
               state_q <= UPS_EMPTY;
            end
         end
         // New beat may replace one that leaves in the same cycle
         if (beat_done) begin
            pend_q <= 1'b1;
         end else if (beat_valid_o) begin
            pend_q <= 1'b0;
         end
      end
   end

   // Low half and its address
   always_ff @(posedge clk_i) begin
      if (req_valid_i && state_q == UPS_EMPTY) begin
         half_addr_q <= req_i.addr;
         half_data_q <= req_i.data;
      end
      if (beat_done) begin
         beat_q <= beat_next;
      end
   end

   assign beat_valid_o = pend_q & ~fifo_full_i;
   assign beat_o       = beat_q;

   // Stall the core while a finished beat is stuck behind a full FIFO
   assign busy_o = fifo_full_i | (pend_q & ~beat_valid_o);

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the outbound path testbench with Verilator and runs it.
# Exits non-zero unless the simulation reports a pass.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --timescale 1ns/10ps \
   -f secure_out_path.f \
   --top-module secure_out_path_tb \
   -o secure_out_path_sim

sim_output=$(./obj_dir/secure_out_path_sim)
echo "$sim_output"

if grep -qx "Verification passed" <<< "$sim_output"; then
   exit 0
else
   exit 1
fi

/* secure_out_path.f */
+incdir+logic
logic/secure_out_pkg.sv
logic/word_upsizer.sv
logic/cdc_src_fifo.sv
logic/cdc_dst_drain.sv
logic/secure_out_path.sv
test/secure_out_path_tb.sv

/* test/secure_out_path_tb.sv */
// Testbench for the secure outbound write path
// Sends directed and random bursts on clk_i, drains beats on clk_ref_i and
// checks each beat against a queue built from the packing rule

`timescale 1ns/10ps

module secure_out_path_tb;

   import secure_out_pkg::*;

   localparam int RAND_BURSTS  = 12;
   localparam int MIXED_BURSTS = 6;
   localparam int FILL_WORDS   = 16;
   localparam int HOLD_LIMIT   = 40;

   logic           clk_i;
   logic           clk_ref_i;
   logic           reset_i;
   logic           req_valid_i;
   narrow_req_t    req_i;
   logic           busy_o;
   logic           out_hold_i;
   logic           out_valid_o;
   wide_beat_t     out_beat_o;

   integer         seed;
   logic [31:0]    hold_rand;
   logic [1:0]     hold_mode;
   logic           busy_while_held = 1'b0;
   int             held_after_busy = 0;
   int             hold_cycles     = 0;

   wide_beat_t     exp_q[$];
   wide_beat_t     exp_beat;
   int             burst_len[RAND_BURSTS + MIXED_BURSTS];
   int             word_total;
   int             push_count = 0;
   int             beat_count = 0;

   // Error counts per checking process
   int             err_data   = 0;
   int             err_hold   = 0;
   int             err_flow   = 0;

   int             cycle_count = 0;
   int             cycle_limit;
   upsizer_state_t ups_state;

   secure_out_path u_secure_out_path (
      .clk_i       ( clk_i       ),
      .clk_ref_i   ( clk_ref_i   ),
      .reset_i     ( reset_i     ),
      .req_valid_i ( req_valid_i ),
      .req_i       ( req_i       ),
      .busy_o      ( busy_o      ),
      .out_hold_i  ( out_hold_i  ),
      .out_valid_o ( out_valid_o ),
      .out_beat_o  ( out_beat_o  )
   );

   initial begin
      clk_i = 1'b0;
      forever begin
         #10 clk_i = ~clk_i;
      end
   end

   initial begin
      clk_ref_i = 1'b0;
      forever begin
         #15 clk_ref_i = ~clk_ref_i;
      end
   end

   function automatic logic [31:0] next_rand();
      next_rand = $random(seed);
   endfunction

   function automatic int total_errors();
      return err_data + err_hold + err_flow;
   endfunction

   // Pair of words with word 0 in the low half
   function automatic wide_beat_t pair_beat(input bus_addr_t addr, input narrow_word_t lo,
                                            input narrow_word_t hi);
      wide_beat_t b;
      b.addr = addr;
      b.data = {hi, lo};
      b.strb = 8'hFF;
      return b;
   endfunction

   function automatic wide_beat_t lone_beat(input bus_addr_t addr, input narrow_word_t w);
      wide_beat_t b;
      b.addr = addr;
      b.data = {32'h0000_0000, w};
      b.strb = 8'h0F;
      return b;
   endfunction

   // Starts and ends 2 ns after a clk_i edge
   task automatic send_word(input bus_addr_t addr, input narrow_word_t data, input logic last);
      while (busy_o) begin
         @(posedge clk_i);
         #2;
      end
      req_valid_i = 1'b1;
      req_i.addr  = addr;
      req_i.data  = data;
      req_i.last  = last;
      @(posedge clk_i);
      #2;
      req_valid_i = 1'b0;
   endtask

   task automatic send_burst(input bus_addr_t base, input int len, input logic use_pattern);
      int           k;
      bus_addr_t    addr;
      narrow_word_t data;
      bus_addr_t    lo_addr;
      narrow_word_t lo_data;
      for (k = 0; k < len; k++) begin
         addr = base + (bus_addr_t'(k) << 2);
         if (use_pattern) begin
            data = 32'h5EC0_0000 + narrow_word_t'(k);
         end else begin
            data = next_rand();
         end
         send_word(addr, data, k == len - 1);
         if (k % 2 == 0) begin
            lo_addr = addr;
            lo_data = data;
            if (k == len - 1) begin
               exp_q.push_back(lone_beat(addr, data));
               push_count = push_count + 1;
            end
         end else begin
            exp_q.push_back(pair_beat(lo_addr, lo_data, data));
            push_count = push_count + 1;
         end
      end
   endtask

   task automatic wait_drained();
      while (exp_q.size() != 0) begin
         @(posedge clk_i);
         #2;
      end
   endtask

   // Hold pattern on the reference clock
   // mode 1 keeps the drain stalled until busy_o has been high for a while
   // or the hold has lasted HOLD_LIMIT cycles
   initial begin
      out_hold_i = 1'b0;
      forever begin
         @(posedge clk_ref_i);
         #2;
         if (hold_mode == 2'd1) begin
            hold_cycles = hold_cycles + 1;
            if (busy_o) begin
               busy_while_held = 1'b1;
            end
            if (busy_while_held) begin
               held_after_busy = held_after_busy + 1;
            end
            out_hold_i = (held_after_busy < 4) && (hold_cycles < HOLD_LIMIT);
         end else if (hold_mode == 2'd2) begin
            hold_rand  = next_rand();
            out_hold_i = (hold_rand[1:0] == 2'b00);
         end else begin
            out_hold_i = 1'b0;
         end
      end
   end

   // Beat checker on the falling reference clock edge
   always @(negedge clk_ref_i) begin
      if (!reset_i && out_valid_o) begin
         beat_count = beat_count + 1;
         if (exp_q.size() == 0) begin
            err_data = err_data + 1;
            $display("Beat on out_valid_o at %0d ns with no beat outstanding", $time);
         end else begin
            exp_beat   = exp_q.pop_front();
            assert (out_beat_o == exp_beat) else begin
               err_data = err_data + 1;
               $display("Mismatch at %0d ns: beat %0d got %h %h %h, expected %h %h %h",
                        $time, beat_count, out_beat_o.addr, out_beat_o.data,
                        out_beat_o.strb, exp_beat.addr, exp_beat.data, exp_beat.strb);
            end
         end
      end
   end

   // No beat may follow a cycle of reset or hold
   assert property (@(posedge clk_ref_i) ($past(reset_i) || $past(out_hold_i)) |-> !out_valid_o)
      else begin
         err_hold = err_hold + 1;
         $display("out_valid_o pulsed at %0d ns after a reset or hold cycle", $time);
      end

   always @(posedge clk_i) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
         ups_state = u_secure_out_path.u_word_upsizer.state_q;
         $display("Timeout after %0d clk_i cycles, %0d beats never arrived, upsizer in %s",
                  cycle_count, exp_q.size(), ups_state.name());
         $display("Checked %0d beats, %0d errors", beat_count, total_errors());
         $display("Verification failed");
         $finish;
      end
   end

   initial begin
      int          i;
      logic [31:0] rnd;

      seed        = 32'haad1bc11;
      reset_i     = 1'b1;
      req_valid_i = 1'b0;
      req_i       = '0;
      hold_mode   = 2'd0;

      // Burst lengths up front so the timeout can be sized
      word_total = 4 + 3 + FILL_WORDS;
      for (i = 0; i < RAND_BURSTS + MIXED_BURSTS; i++) begin
         rnd          = next_rand();
         burst_len[i] = int'(rnd[2:0]) + 1;
         word_total   = word_total + burst_len[i];
      end
      cycle_limit = 4 * word_total + 200;

      repeat (3) @(posedge clk_i);
      #2;
      reset_i = 1'b0;

      assert (!busy_o && !out_valid_o) else begin
         err_flow = err_flow + 1;
         $display("Mismatch at %0d ns: busy_o %b out_valid_o %b after reset, expected 0 0",
                  $time, busy_o, out_valid_o);
      end
      repeat (10) begin
         @(posedge clk_i);
         #2;
         assert (!out_valid_o) else begin
            err_flow = err_flow + 1;
            $display("Mismatch at %0d ns: out_valid_o high with no request sent", $time);
         end
      end

      // One even and one odd burst with known data
      send_burst(32'h1000_0000, 4, 1'b1);
      send_burst(32'h2000_0040, 3, 1'b1);
      wait_drained();

      for (i = 0; i < RAND_BURSTS; i++) begin
         rnd = next_rand();
         send_burst({rnd[31:8], 8'h00}, burst_len[i], 1'b0);
      end
      wait_drained();

      // Drain stalled until the FIFO and then the upsizer fill up
      hold_mode = 2'd1;
      wait (out_hold_i);
      @(posedge clk_i);
      #2;
      send_burst(32'h3000_0000, FILL_WORDS, 1'b0);
      wait_drained();
      assert (busy_while_held) else begin
         err_flow = err_flow + 1;
         $display("busy_o never rose while the drain was held");
      end

      hold_mode = 2'd2;
      for (i = 0; i < MIXED_BURSTS; i++) begin
         rnd = next_rand();
         send_burst({rnd[31:8], 8'h00}, burst_len[RAND_BURSTS + i], 1'b0);
      end
      wait_drained();
      hold_mode = 2'd0;

      // Idle tail to catch stray beats
      repeat (10) begin
         @(posedge clk_i);
         #2;
      end

      assert (beat_count == push_count) else begin
         err_flow = err_flow + 1;
         $display("Mismatch at %0d ns: %0d beats arrived, expected %0d",
                  $time, beat_count, push_count);
      end

      $display("Checked %0d beats, %0d errors", beat_count, total_errors());
      if (total_errors() == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule
